// ==== rv_core_pkg.sv ====
package rv_core_pkg;

  // datapath widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes handled by the core
  localparam logic [6:0] op_reg_imm  = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg  = 7'b01_100_11;
  localparam logic [6:0] op_lui      = 7'b01_101_11;
  localparam logic [6:0] op_auipc    = 7'b00_101_11;
  localparam logic [6:0] op_environ  = 7'b11_100_11;

  // recognized but not executed, these decode to bubbles
  localparam logic [6:0] op_load     = 7'b00_000_11;
  localparam logic [6:0] op_store    = 7'b01_000_11;
  localparam logic [6:0] op_branch   = 7'b11_000_11;
  localparam logic [6:0] op_jal      = 7'b11_011_11;
  localparam logic [6:0] op_jalr     = 7'b11_001_11;
  localparam logic [6:0] op_misc_mem = 7'b00_011_11;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // one-hot status of the writeback slot, zero is invalid
  typedef enum logic [5:0] {
    cycle_reset    = 6'd1,
    cycle_no_stall = 6'd2
  } cycle_status_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    use_pc;
    logic    rd_we;
    logic    is_halt;
  } ctrl_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    ctrl_t         ctrl;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    word_t         rs1_data;
    word_t         rs2_data;
    word_t         imm;
  } execute_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    logic          rd_we;
    reg_idx_t      rd;
    word_t         rd_data;
  } wb_trace_t;

endpackage

// ==== rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu import rv_core_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   y
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        y = a + b;
      end
      alu_sub: begin
        y = a - b;
      end
      alu_sll: begin
        y = a << shamt;
      end
      alu_slt: begin
        y = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        y = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_xor: begin
        y = a ^ b;
      end
      alu_srl: begin
        y = a >> shamt;
      end
      alu_sra: begin
        y = $unsigned($signed(a) >>> shamt);
      end
      alu_or: begin
        y = a | b;
      end
      alu_and: begin
        y = a & b;
      end
      // lui, immediate already shifted by decode
      alu_pass_b: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder import rv_core_pkg::*; (
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output ctrl_t    ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_shamt;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i     = {{20{insn[31]}}, insn[31:20]};
  assign imm_u     = {insn[31:12], 12'b0};
  assign imm_shamt = {27'b0, insn[24:20]};

  always_comb begin
    // anything not matched below leaves a no-write bubble
    ctrl = '0;
    imm  = imm_i;
    case (opcode)
      op_reg_imm: begin
        ctrl.use_imm = 1'b1;
        ctrl.rd_we   = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b010: ctrl.alu_op = alu_slt;
          3'b011: ctrl.alu_op = alu_sltu;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          3'b001: begin
            ctrl.alu_op = alu_sll;
            imm         = imm_shamt;
            ctrl.rd_we  = (funct7 == 7'b0000000);
          end
          default: begin
            // srli and srai share funct3 101
            ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
            imm         = imm_shamt;
            ctrl.rd_we  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      op_reg_reg: begin
        ctrl.rd_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = alu_add;
          10'b0100000_000: ctrl.alu_op = alu_sub;
          10'b0000000_001: ctrl.alu_op = alu_sll;
          10'b0000000_010: ctrl.alu_op = alu_slt;
          10'b0000000_011: ctrl.alu_op = alu_sltu;
          10'b0000000_100: ctrl.alu_op = alu_xor;
          10'b0000000_101: ctrl.alu_op = alu_srl;
          10'b0100000_101: ctrl.alu_op = alu_sra;
          10'b0000000_110: ctrl.alu_op = alu_or;
          10'b0000000_111: ctrl.alu_op = alu_and;
          default:         ctrl.rd_we  = 1'b0;
        endcase
      end
      op_lui: begin
        ctrl.alu_op  = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.rd_we   = 1'b1;
        imm          = imm_u;
      end
      op_auipc: begin
        ctrl.alu_op  = alu_add;
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.rd_we   = 1'b1;
        imm          = imm_u;
      end
      // only a clean ecall halts
      op_environ: ctrl.is_halt = (insn[31:7] == 25'd0);
      // memory and control flow are not built in this core
      op_load, op_store, op_branch, op_jal, op_jalr, op_misc_mem: ctrl.rd_we = 1'b0;
      default: ctrl.rd_we = 1'b0;
    endcase
  end

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch import rv_core_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    halt,
  input  word_t   insn,
  output word_t   pc,
  output decode_t decode
);

  // program counter, stops once the ecall reaches writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      pc <= pc + 32'd4;
    end
  end

  // fetch to decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      decode        <= '0;
      decode.status <= cycle_reset;
    end else if (!halt) begin
      decode <= '{pc: pc, insn: insn, status: cycle_no_stall};
    end
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  // x0 has no storage
  word_t regs [1:31];

  // write-through so decode sees the value retiring this cycle
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we && wr_idx == idx) begin
      return wr_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  decode_t   decode,
  input  ctrl_t     ctrl,
  input  reg_idx_t  rs1,
  input  reg_idx_t  rs2,
  input  reg_idx_t  rd,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  word_t     imm,
  output logic      halt,
  output wb_trace_t wb_trace
);

  execute_t ex;
  logic     fwd_ok;
  word_t    rs1_fwd;
  word_t    rs2_fwd;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_y;

  // bypass from writeback, x0 never forwards
  assign fwd_ok  = wb_trace.rd_we && (wb_trace.rd != '0);
  assign rs1_fwd = (fwd_ok && wb_trace.rd == ex.rs1) ? wb_trace.rd_data : ex.rs1_data;
  assign rs2_fwd = (fwd_ok && wb_trace.rd == ex.rs2) ? wb_trace.rd_data : ex.rs2_data;

  assign alu_a = ex.ctrl.use_pc ? ex.pc : rs1_fwd;
  assign alu_b = ex.ctrl.use_imm ? ex.imm : rs2_fwd;

  rv_alu alu_inst (
    .op (ex.ctrl.alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  // both stage registers freeze once the ecall sits in writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      ex              <= '0;
      ex.status       <= cycle_reset;
      wb_trace        <= '0;
      wb_trace.status <= cycle_reset;
      halt            <= 1'b0;
    end else if (!halt) begin
      ex <= '{pc: decode.pc, insn: decode.insn, status: decode.status, ctrl: ctrl,
              rs1: rs1, rs2: rs2, rd: rd, rs1_data: rs1_data, rs2_data: rs2_data,
              imm: imm};
      wb_trace <= '{pc: ex.pc, insn: ex.insn, status: ex.status, rd_we: ex.ctrl.rd_we,
                    rd: ex.rd, rd_data: alu_y};
      halt <= ex.ctrl.is_halt;
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_core_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clk,
  input  logic      rst,
  output word_t     pc,
  input  word_t     insn,
  output logic      halt,
  output wb_trace_t wb_trace
);

  decode_t  decode;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  ctrl_t    ctrl;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_inst (
    .clk    (clk),
    .rst    (rst),
    .halt   (halt),
    .insn   (insn),
    .pc     (pc),
    .decode (decode)
  );

  rv_decoder decoder_inst (
    .insn (decode.insn),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd),
    .imm  (imm),
    .ctrl (ctrl)
  );

  // write port fed straight from the writeback slot
  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_trace.rd_we),
    .wr_idx   (wb_trace.rd),
    .wr_data  (wb_trace.rd_data)
  );

  rv_execute execute_inst (
    .clk      (clk),
    .rst      (rst),
    .decode   (decode),
    .ctrl     (ctrl),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .halt     (halt),
    .wb_trace (wb_trace)
  );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core import rv_core_pkg::*;;

  localparam int    clk_period     = 4;
  localparam int    drive_delay    = 1;
  localparam int    reset_cycles   = 8;
  localparam int    reset_slots    = 3;
  localparam int    hold_cycles    = 10;
  localparam int    timeout_cycles = 200;
  localparam int    imem_depth     = 64;
  localparam int    trace_max      = 64;
  localparam word_t ecall_word     = 32'h0000_0073;
  // fetch runs three instructions ahead of writeback
  localparam word_t fetch_lead     = 32'd12;

  logic      clk;
  logic      rst;
  word_t     pc;
  word_t     insn;
  logic      halt;
  wb_trace_t wb_trace;

  // instruction memory and raw trace words at four per line
  word_t     imem [0:imem_depth-1];
  word_t     trace_mem [0:trace_max*4-1];
  wb_trace_t expected_q [$];

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) rv_core_inst (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .halt     (halt),
    .wb_trace (wb_trace)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // memory answers the pc of this cycle
  initial begin
    insn = '0;
    forever begin
      @(posedge clk);
      #drive_delay;
      insn = imem[pc[7:2]];
    end
  end

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_status(cycle_status_e got, cycle_status_e exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t ns: %s status is %b, expected %s",
                         $time, what, got, exp.name()));
    end
  endtask

  task automatic check_pc(word_t got, word_t exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t ns: %s fetch pc is %h, expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_wb(wb_trace_t got, wb_trace_t exp, bit all_fields, string what);
    check_status(got.status, exp.status, what);
    if (got.pc !== exp.pc) begin
      stop_run($sformatf("Mismatch at %0t ns: %s pc is %h, expected %h",
                         $time, what, got.pc, exp.pc));
    end
    if (got.insn !== exp.insn) begin
      stop_run($sformatf("Mismatch at %0t ns: %s insn is %h, expected %h",
                         $time, what, got.insn, exp.insn));
    end
    if (got.rd_we !== exp.rd_we) begin
      stop_run($sformatf("Mismatch at %0t ns: %s rd_we is %b, expected %b",
                         $time, what, got.rd_we, exp.rd_we));
    end
    // bubbles carry whatever the datapath left in rd and rd_data
    if (exp.rd_we || all_fields) begin
      if (got.rd !== exp.rd) begin
        stop_run($sformatf("Mismatch at %0t ns: %s rd is x%0d, expected x%0d",
                           $time, what, got.rd, exp.rd));
      end
      if (got.rd_data !== exp.rd_data) begin
        stop_run($sformatf("Mismatch at %0t ns: %s rd_data is %h, expected %h",
                           $time, what, got.rd_data, exp.rd_data));
      end
    end
  endtask

  task automatic load_trace();
    wb_trace_t exp;
    int        n;
    bit        found;
    found = 1'b0;
    n = 0;
    // unused words are addi x0 nops tagged with their index
    for (int i = 0; i < imem_depth; i++) begin
      imem[i] = {i[11:0], 20'h00013};
    end
    for (int i = 0; i < trace_max * 4; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("rv_core_trace.txt", trace_mem);
    while (!found && n < trace_max) begin
      exp.pc      = word_t'(n * 4);
      exp.insn    = trace_mem[n * 4];
      exp.status  = cycle_no_stall;
      exp.rd_we   = trace_mem[n * 4 + 1][0];
      exp.rd      = trace_mem[n * 4 + 2][4:0];
      exp.rd_data = trace_mem[n * 4 + 3];
      imem[n] = exp.insn;
      expected_q.push_back(exp);
      found = (exp.insn == ecall_word);
      n++;
    end
    if (!found) begin
      stop_run("the trace file holds no ecall to end the program");
    end
  endtask

  initial begin
    wb_trace_t reset_slot;
    wb_trace_t exp;
    wb_trace_t held;
    int        cycles;
    rst = 1'b1;
    reset_slot = '0;
    reset_slot.status = cycle_reset;
    load_trace();
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b0;

    // pipeline still drains reset bubbles
    for (int c = 0; c < reset_slots; c++) begin
      @(negedge clk);
      check_wb(wb_trace, reset_slot, 1'b0, "reset slot");
      check_pc(pc, word_t'(c * 4), "reset slot");
      if (halt !== 1'b0) begin
        stop_run($sformatf("Mismatch at %0t ns: halt is %b during reset slots", $time, halt));
      end
    end

    // one program slot per cycle until halt shows up
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        stop_run("timeout: halt did not rise while the program ran");
      end
      if (expected_q.size() == 0) begin
        stop_run("writeback went past the last trace entry and halt stayed low");
      end
      exp = expected_q.pop_front();
      check_wb(wb_trace, exp, 1'b0, $sformatf("slot at pc %h", exp.pc));
      check_pc(pc, exp.pc + fetch_lead, $sformatf("slot at pc %h", exp.pc));
    end while (!halt);

    if (exp.insn !== ecall_word) begin
      stop_run($sformatf("Mismatch at %0t ns: halt rose with insn %h in writeback",
                         $time, exp.insn));
    end

    // frozen core keeps the ecall in writeback
    held = wb_trace;
    for (int c = 0; c < hold_cycles; c++) begin
      @(negedge clk);
      if (halt !== 1'b1) begin
        stop_run($sformatf("Mismatch at %0t ns: halt dropped to %b after the ecall",
                           $time, halt));
      end
      check_wb(wb_trace, held, 1'b1, "halted slot");
      check_pc(pc, exp.pc + fetch_lead, "halted slot");
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== rv_core.f ====
rv_core_pkg.sv
rv_alu.sv
rv_decoder.sv
rv_fetch.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timescale 1ns/1ns --top-module tb_rv_core -f rv_core.f -o tb_rv_core
	@out=$$(./obj_dir/tb_rv_core); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== rv_core_trace.txt ====
// columns: instruction word, expected rd_we, expected rd, expected rd value
// rd and value are not checked on lines where rd_we is 0
00500093 1 01 00000005
ffd00113 1 02 fffffffd
002081b3 1 03 00000002
40118233 1 04 fffffffd
001222b3 1 05 00000001
00123333 1 06 00000000
0f00c393 1 07 000000f5
7003e413 1 08 000007f5
ff047493 1 09 000007f0
01c09513 1 0a 50000000
00415593 1 0b 0fffffff
40115613 1 0c fffffffe
123456b7 1 0d 12345000
00001717 1 0e 00001034
001697b3 1 0f 468a0000
00115833 1 10 07ffffff
405158b3 1 11 fffffffe
0083c933 1 12 00000700
001969b3 1 13 00000705
0089fa33 1 14 00000705
00708013 1 00 0000000c
00100ab3 1 15 00000005
0000ab03 0 00 00000000
00208463 0 00 00000000
02208bb3 0 00 00000000
40309c13 0 00 00000000
001c0cb3 1 19 00000005
00000073 0 00 00000000
